// File: read_dma_macros.svh
//**********************************************************************
// build-time constants for the read DMA subsystem
// include from any package or module that needs widths, FIFO depth
// or the throttle headroom
//**********************************************************************

`ifndef READ_DMA_MACROS_SVH
`define READ_DMA_MACROS_SVH

// bus word and byte address widths
`define DMA_DATA_W 32
`define DMA_ADDR_W 32

// bytes in one bus word, also the address and length step
`define DMA_BYTES_PER_WORD (`DMA_DATA_W / 8)

// read buffer size, keep depth a power of two
`define DMA_FIFO_DEPTH 32
`define DMA_FIFO_DEPTH_LOG2 5

// words of headroom left free for reads posted while the
// registered throttle decision catches up
`define DMA_THROTTLE_MARGIN 4

`endif

// File: bus_pkg.sv
//**********************************************************************
// memory bus types for the pipelined read bus
// request struct is driven by the read master, response struct by
// the slave; import with a wildcard in the module header
//**********************************************************************

`include "read_dma_macros.svh"

package bus_pkg;

	// one data word on the bus
	typedef logic [`DMA_DATA_W-1:0] dma_data_t;

	// byte address, always word aligned in this design
	typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

	// one enable bit per byte lane
	typedef logic [`DMA_BYTES_PER_WORD-1:0] dma_be_t;

	// words held in the read buffer, one extra bit so full fits
	typedef logic [`DMA_FIFO_DEPTH_LOG2:0] fifo_level_t;

	// master to slave
	typedef struct packed {
		dma_addr_t address;     // held while waitrequest is high
		logic      read;        // request a word
		dma_be_t   byteenable;  // all lanes, word reads only
	} bus_req_t;

	// slave to master
	typedef struct packed {
		dma_data_t readdata;       // valid with readdatavalid
		logic      readdatavalid;  // one pulse per accepted read, in order
		logic      waitrequest;    // stalls the current request
	} bus_rsp_t;

endpackage

// File: job_pkg.sv
//**********************************************************************
// job level types: the start command, the checksum result and the
// consumer state machine encoding
// depends on bus_pkg for the address and data vectors
//**********************************************************************

`include "read_dma_macros.svh"

package job_pkg;

	import bus_pkg::*;

	// transfer length in bytes, multiple of the word size
	typedef logic [`DMA_ADDR_W-1:0] dma_len_t;

	// start of a job, sampled only while the subsystem is done
	typedef struct packed {
		logic      go;              // single cycle start pulse
		dma_addr_t base;            // word aligned first address
		dma_len_t  length;          // bytes to read
		logic      fixed_location;  // reread base for every word
	} job_cmd_t;

	// what the consumer reports at the end of a job
	typedef struct packed {
		dma_data_t sum;         // running sum mod 2^32
		dma_data_t xor_all;     // xor of every word
		dma_len_t  word_count;  // words consumed
	} job_result_t;

	// consumer FSM
	typedef enum logic {
		IDLE,  // waiting for go, result stable
		RUN    // draining the buffer for the current job
	} sink_state_t;

endpackage

// File: showahead_fifo.sv
//**********************************************************************
// synchronous show-ahead FIFO for returned read data
// head is the oldest word and is valid whenever empty is low; pop
// drops it at the clock edge. used feeds the master's throttle
//**********************************************************************

`timescale 1ns/1ps
`include "read_dma_macros.svh"

module showahead_fifo import bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        push,       // write push_data this edge
	input  dma_data_t   push_data,
	input  logic        pop,        // drop head this edge
	output dma_data_t   head,       // oldest word, combinational
	output logic        empty,
	output fifo_level_t used        // words currently stored
);

	typedef logic [`DMA_FIFO_DEPTH_LOG2-1:0] fifo_ptr_t;

	dma_data_t   mem [`DMA_FIFO_DEPTH];  // storage, no reset needed
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_level_t count;
	logic        full;

	// storage write, pointers wrap on their own since depth is 2^n
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// count only moves when one side is active alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head  = mem[rd_ptr];  // show-ahead read port
	assign empty = (count == '0);
	assign full  = (count == fifo_level_t'(`DMA_FIFO_DEPTH));
	assign used  = count;

	// the master's throttle must keep the buffer from ever overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		full |-> !push)
		else $error("push into a full FIFO");

	// consumer may only pop what is there
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		empty |-> !pop)
		else $error("pop from an empty FIFO");

endmodule

// File: latency_aware_read_master.sv
//**********************************************************************
// read master for the pipelined memory bus
// loads base and length on go, posts word reads until the length is
// used up, counts reads still in flight and throttles itself so that
// buffered plus pending words stay within the FIFO
//**********************************************************************

`timescale 1ns/1ps
`include "read_dma_macros.svh"

module latency_aware_read_master import bus_pkg::*, job_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  job_cmd_t    cmd,          // go already qualified by done
	output bus_req_t    bus_req,
	input  bus_rsp_t    bus_rsp,
	input  fifo_level_t fifo_used,    // words waiting in the buffer
	output logic        master_idle   // length spent and nothing in flight
);

	dma_addr_t   address;
	dma_len_t    length;                   // bytes left to request
	logic        fixed;                    // latched fixed_location
	fifo_level_t reads_pending;            // accepted but not returned
	logic        throttle_q;               // registered throttle decision
	logic        wait_hold;                // read was stalled last cycle
	logic        read;
	logic        accept;                   // read taken by the slave
	logic        too_many;
	logic [`DMA_FIFO_DEPTH_LOG2+1:0] in_flight;  // used plus pending

	// a stalled read stays up even if the throttle trips meanwhile,
	// the margin absorbs that one extra word
	assign read   = (length != '0) & (!throttle_q | wait_hold);
	assign accept = read & !bus_rsp.waitrequest;

	always_comb
	begin
		bus_req.address    = address;
		bus_req.read       = read;
		bus_req.byteenable = '1;  // word reads only
	end

	// address and length counters
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			address <= '0;
			length  <= '0;
			fixed   <= 1'b0;
		end
		else if (cmd.go)
		begin
			address <= cmd.base;
			length  <= cmd.length;
			fixed   <= cmd.fixed_location;
		end
		else if (accept)
		begin
			if (!fixed)
				address <= address + dma_addr_t'(`DMA_BYTES_PER_WORD);
			length <= length - dma_len_t'(`DMA_BYTES_PER_WORD);
		end
	end

	// pending counter, a read in and a read out cancel
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			reads_pending <= '0;
		else
		begin
			case ({accept, bus_rsp.readdatavalid})
				2'b10:   reads_pending <= reads_pending + 1'b1;
				2'b01:   reads_pending <= reads_pending - 1'b1;
				default: reads_pending <= reads_pending;
			endcase
		end
	end

	assign in_flight = fifo_used + reads_pending;
	assign too_many  = in_flight >= (`DMA_FIFO_DEPTH - `DMA_THROTTLE_MARGIN);

	// throttle lags one cycle, keeps the compare off the read path
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			throttle_q <= 1'b0;
			wait_hold  <= 1'b0;
		end
		else
		begin
			throttle_q <= too_many;
			wait_hold  <= read & bus_rsp.waitrequest;
		end
	end

	assign master_idle = (length == '0) & (reads_pending == '0);

	// jobs must be whole words from an aligned base
	a_go_aligned: assert property (@(posedge clk) disable iff (reset)
		cmd.go |-> ((cmd.length % `DMA_BYTES_PER_WORD) == 0) &&
			((cmd.base % `DMA_BYTES_PER_WORD) == 0))
		else $error("go with unaligned base or length");

	a_pending_bound: assert property (@(posedge clk) disable iff (reset)
		reads_pending <= fifo_level_t'(`DMA_FIFO_DEPTH))
		else $error("more reads in flight than the FIFO can hold");

	// bus rule, a waited request holds read and address
	a_addr_hold: assert property (@(posedge clk) disable iff (reset)
		(read && bus_rsp.waitrequest) |=> (read && $stable(address)))
		else $error("request changed while waitrequest was high");

endmodule

// File: stream_checksum.sv
//**********************************************************************
// consumer of the read buffer
// pops the FIFO head while drain_enable is high and folds every word
// into a running sum, xor and count; goes idle once the master has
// finished and the buffer is empty
//**********************************************************************

`timescale 1ns/1ps

module stream_checksum import bus_pkg::*, job_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        go,            // qualified job start
	input  dma_data_t   head,          // show-ahead FIFO output
	input  logic        empty,
	input  logic        drain_enable,  // external flow control
	input  logic        master_idle,
	output logic        pop,
	output job_result_t result,
	output logic        idle
);

	sink_state_t state;
	job_result_t acc;  // accumulators that also form the reported result

	// only drain during a job
	assign pop = (state == RUN) & !empty & drain_enable;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			acc   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (go)
					begin
						acc   <= '0;  // fresh totals per job
						state <= RUN;
					end
				end
				RUN:
				begin
					if (pop)
					begin
						acc.sum        <= acc.sum + head;  // wraps mod 2^32
						acc.xor_all    <= acc.xor_all ^ head;
						acc.word_count <= acc.word_count + 1'b1;
					end
					// a word landing this edge keeps empty low next cycle
					if (master_idle && empty)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign result = acc;
	assign idle   = (state == IDLE);

endmodule

// File: read_dma_top.sv
//**********************************************************************
// read DMA subsystem top level
// a go pulse while done is high starts a job; the master reads the
// bus into the FIFO and the checksum consumer drains it. result is
// valid while done is high and holds until the next go
//**********************************************************************

`timescale 1ns/1ps

module read_dma_top import bus_pkg::*, job_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  job_cmd_t    cmd,
	output bus_req_t    bus_req,
	input  bus_rsp_t    bus_rsp,
	input  logic        drain_enable,
	output job_result_t result,
	output logic        done
);

	job_cmd_t    job;          // cmd with go masked by done
	logic        master_idle;
	logic        fifo_empty;
	logic        fifo_pop;
	dma_data_t   fifo_head;
	fifo_level_t fifo_used;
	logic        sink_idle;

	// go is ignored while a job is still running
	always_comb
	begin
		job    = cmd;
		job.go = cmd.go & done;
	end

	latency_aware_read_master u_master (
		.clk         (clk),
		.reset       (reset),
		.cmd         (job),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.fifo_used   (fifo_used),
		.master_idle (master_idle)
	);

	// every returned word goes straight in
	showahead_fifo u_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (bus_rsp.readdatavalid),
		.push_data (bus_rsp.readdata),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.empty     (fifo_empty),
		.used      (fifo_used)
	);

	stream_checksum u_sink (
		.clk          (clk),
		.reset        (reset),
		.go           (job.go),
		.head         (fifo_head),
		.empty        (fifo_empty),
		.drain_enable (drain_enable),
		.master_idle  (master_idle),
		.pop          (fifo_pop),
		.result       (result),
		.idle         (sink_idle)
	);

	// all reads back, buffer drained, consumer finished
	assign done = master_idle & fifo_empty & sink_idle;

endmodule

// File: tb_read_dma.sv
//**********************************************************************
// testbench for the read DMA subsystem
// jobs and expected totals come from read_dma_vectors.txt; a memory
// slave model adds random waitrequest and 1 to 8 cycle latency, and
// every job's count, sum and xor are checked when done returns
//**********************************************************************

`timescale 1ns/1ps
`include "read_dma_macros.svh"

module tb_read_dma import bus_pkg::*, job_pkg::*;
();

	// one line of the vector file
	typedef struct packed {
		dma_addr_t base;
		dma_len_t  length;
		logic      fixed;
		logic      drain;    // 1 = random drain_enable stalls
		dma_len_t  count;
		dma_data_t sum;
		dma_data_t xor_all;
	} vector_t;

	// accepted read waiting for its data phase
	typedef struct packed {
		dma_addr_t   address;
		logic [31:0] due;  // cycle in which readdatavalid is driven
	} pending_t;

	logic        clk = 1'b0;
	logic        reset;
	job_cmd_t    cmd;
	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic        drain_enable;
	job_result_t result;
	logic        done;

	vector_t     jobs[$];
	pending_t    pend_q[$];        // in order like the bus
	logic [31:0] seed = 32'had3e;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int          cycle_limit = 1000000;  // set from the job lengths
	int          accept_idx = 0;   // reads accepted in this job
	int          read_cycles = 0;  // cycles with read high in this job
	int          last_due = 0;
	int          drain_left = 0;   // cycles left in the current drain phase
	logic        drain_on = 1'b1;
	dma_addr_t   job_base = '0;
	logic        job_fixed = 1'b0;
	logic        job_drain = 1'b0;

	always #10 clk = ~clk;  // 20 ns period

	read_dma_top uut (
		.clk          (clk),
		.reset        (reset),
		.cmd          (cmd),
		.bus_req      (bus_req),
		.bus_rsp      (bus_rsp),
		.drain_enable (drain_enable),
		.result       (result),
		.done         (done)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// memory contents as a function of the whole byte address
	function automatic dma_data_t mem_word(input dma_addr_t a);
		return (a * 32'h9e3779b1) ^ 32'h5a5a5a5a;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s, got %h expected %h",
				$time, what, actual, expected);
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f[7];  // fields of one line
		vector_t     v;
		fd = $fopen("read_dma_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open read_dma_vectors.txt, no jobs to run");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#")  // # starts a comment line
				begin
					n = $sscanf(line, "%h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
					if (n == 7)
					begin
						v = {f[0], f[1], f[2][0], f[3][0], f[4], f[5], f[6]};
						jobs.push_back(v);
					end
				end
			end
			$fclose(fd);
			if (jobs.size() == 0)
			begin
				$display("read_dma_vectors.txt holds no job lines");
				errors++;
			end
		end
	endtask

	// memory slave model and drain control decided on the falling edge
	always @(negedge clk)
	begin : mem_model
		logic [31:0] r;
		bus_rsp_t    rsp;
		pending_t    p;
		int          delay;
		logic        accepted;
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: done did not return within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
		else if (reset)
		begin
			bus_rsp      <= '0;
			drain_enable <= 1'b0;
		end
		else
		begin
			rsp = '0;
			if (pend_q.size() > 0 && int'(pend_q[0].due) <= cycle_count)
			begin
				rsp.readdatavalid = 1'b1;
				rsp.readdata      = mem_word(pend_q[0].address);
				void'(pend_q.pop_front());
			end
			r = lcg_next();
			rsp.waitrequest = (r[31:30] == 2'b00);  // stall about one cycle in four
			accepted = bus_req.read && !rsp.waitrequest;
			if (accepted)
			begin
				check_value(bus_req.address,
					job_fixed ? job_base : job_base + 4 * accept_idx, "read address");
				check_value(bus_req.byteenable, dma_be_t'('1), "byteenable not all ones");
				delay = (lcg_next() >> 16) % 8 + 1;
				p.address = bus_req.address;
				// one data phase per cycle keeps the return order
				p.due = (cycle_count + delay > last_due) ? cycle_count + delay : last_due + 1;
				last_due = p.due;
				pend_q.push_back(p);
			end
			if (done)
			begin
				accept_idx  <= 0;  // next job counts from zero
				read_cycles <= 0;
			end
			else
			begin
				if (accepted)
					accept_idx <= accept_idx + 1;
				if (bus_req.read)
					read_cycles <= read_cycles + 1;
				// in flight plus buffered as seen from the ports
				check_value((accept_idx - int'(result.word_count)) <= `DMA_FIFO_DEPTH, 1'b1,
					"reads outstanding plus buffered above FIFO depth");
			end
			if (!job_drain)
				drain_enable <= 1'b1;
			else
			begin
				if (drain_left == 0)
				begin
					r = lcg_next();
					drain_on   = r[31];
					drain_left = r[30:26] + 4;  // long phases of 4 to 35 cycles
				end
				else
					drain_left--;
				drain_enable <= drain_on;
			end
			bus_rsp <= rsp;
		end
	end

	initial
	begin
		vector_t cur;
		int      total_words;
		reset        = 1'b1;
		cmd          = '0;
		bus_rsp      = '0;
		drain_enable = 1'b0;
		total_words  = 0;
		load_vectors();
		foreach (jobs[i])
			total_words += jobs[i].length / `DMA_BYTES_PER_WORD;
		cycle_limit = total_words * 40 + 2000;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		repeat (2) @(negedge clk);
		check_value(bus_req.read, 1'b0, "read high after reset");
		check_value(done, 1'b1, "done low after reset");
		foreach (jobs[j])
		begin
			cur = jobs[j];
			job_base  <= cur.base;
			job_fixed <= cur.fixed;
			job_drain <= cur.drain;
			cmd.go             = 1'b1;  // one cycle pulse
			cmd.base           = cur.base;
			cmd.length         = cur.length;
			cmd.fixed_location = cur.fixed;
			@(negedge clk);
			cmd = '0;
			while (!done)
				@(negedge clk);
			check_value(result.word_count, cur.count, "word count");
			check_value(result.sum, cur.sum, "sum");
			check_value(result.xor_all, cur.xor_all, "xor");
			check_value(accept_idx, cur.count, "accepted reads");
			if (cur.length == '0)
				check_value(read_cycles, 0, "read raised on a zero-length job");
			@(negedge clk);
		end
		repeat (5) @(negedge clk);
		$display("jobs: %0d  checks: %0d  errors: %0d", jobs.size(), checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: read_dma_vectors.txt
# one job per line, all fields hex: base length fixed drain exp_count exp_sum exp_xor
# drain 0 keeps drain_enable high, 1 gives random long stalls
# incrementing jobs
00000000 00000020 0 0 00000008 bc798180 c7ffa200
00000004 0000000c 0 0 00000003 ff2d4286 b9a5c55a
00000010 00000010 0 1 00000004 62f1e4a0 24003d00
00000008 00000004 0 1 00000001 abe197d2 abe197d2
0000000c 00000010 0 1 00000004 7f6abdb0 0088c610
00000000 00000020 0 1 00000008 bc798180 c7ffa200
# zero length, done must come back with empty totals
00000000 00000000 0 0 00000000 00000000 00000000
# fixed location, long enough to hit the throttle
00000004 00000100 1 1 00000040 a1ef2780 00000000
00000014 0000008c 1 0 00000023 d42b046a 060fdb8e
0000001c 00000084 1 1 00000021 9dadb5c6 144b1506
00000000 000000c8 1 0 00000032 a5a5a594 00000000
00000000 000000c8 1 1 00000032 a5a5a594 00000000
00000008 00000000 1 1 00000000 00000000 00000000
# short incrementing job after the long ones
00000004 0000000c 0 1 00000003 ff2d4286 b9a5c55a

// File: read_dma.f
+incdir+.
bus_pkg.sv
job_pkg.sv
showahead_fifo.sv
latency_aware_read_master.sv
stream_checksum.sv
read_dma_top.sv
tb_read_dma.sv

// File: Bender.yml
package:
  name: read_dma

export_include_dirs:
  - .

sources:
  - bus_pkg.sv
  - job_pkg.sv
  - showahead_fifo.sv
  - latency_aware_read_master.sv
  - stream_checksum.sv
  - read_dma_top.sv
  - target: simulation
    files:
      - tb_read_dma.sv
